// ==== verilog.f ====
+incdir+include
verilog/booth_ctrl_pkg.sv
verilog/booth_data_pkg.sv
verilog/booth_datapath.sv
verilog/booth_controller.sv
verilog/booth_multiplier.sv
testbench/tb_booth_multiplier.sv

// ==== testbench/tb_booth_multiplier.sv ====
`timescale 1ns/1ps

module tb_booth_multiplier;

    localparam int NUM_TRANS   = 52;                       // 4 + 4 + 40 + 1 + 3
    localparam int RESET_CYC   = 4;
    localparam int TIMEOUT_CYC = NUM_TRANS * 24 + RESET_CYC + 100;
    localparam int LATENCY     = 18;                       // req sampled to ack
    localparam int ACK_WAIT    = 40;                       // Give up on ack after this

    logic                     clk;
    logic                     rst_n;
    logic                     req;
    booth_data_pkg::operand_t multiplicand;
    booth_data_pkg::operand_t multiplier;
    logic                     ack;
    booth_data_pkg::product_t product;

    int          value_errors;
    int          protocol_errors;
    int          cycles;
    logic [15:0] lfsr_state;

    booth_multiplier dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .ack          (ack),
        .product      (product)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 16'hB400;
        return n;
    endfunction

    // One LFSR step per operand bit
    task automatic draw_operand(output booth_data_pkg::operand_t v);
        v = '0;
        for (int i = 0; i < 16; i++) begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Plain signed product, widened before multiplying
    function automatic booth_data_pkg::product_t ref_product(
        input booth_data_pkg::operand_t a,
        input booth_data_pkg::operand_t b
    );
        longint pa;
        longint pb;
        pa = a;   // Sign extends
        pb = b;
        return booth_data_pkg::product_t'(pa * pb);
    endfunction

    // Full four-phase transfer, hold = extra cycles req stays high after ack
    task automatic multiply(input booth_data_pkg::operand_t a,
                            input booth_data_pkg::operand_t b, input int hold);
        booth_data_pkg::product_t expected;
        int latency;
        int fall_wait;
        expected = ref_product(a, b);
        @(posedge clk);
        req          <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        @(posedge clk);            // Edge k, req first sampled high
        latency = 1;               // ack seen at this negedge is sampled at edge k+1
        @(negedge clk);
        while (!ack && latency < ACK_WAIT) begin
            @(negedge clk);
            latency++;
        end
        assert (ack === 1'b1) else begin
            protocol_errors++;
            $display("No ack within %0d cycles of req for %h x %h", ACK_WAIT, a, b);
        end
        if (ack === 1'b1) begin
            assert (latency == LATENCY) else begin
                value_errors++;
                $display("error: ack latency got %h expected %h", latency, LATENCY);
            end
            assert (product === expected) else begin
                value_errors++;
                $display("error: product got %h expected %h", product, expected);
            end
        end
        for (int i = 0; i < hold; i++) begin   // Back-pressure, DUT must stall
            @(negedge clk);
            assert (ack === 1'b1) else begin
                value_errors++;
                $display("error: ack got %h expected %h", ack, 1'b1);
            end
            assert (product === expected) else begin
                value_errors++;
                $display("error: product got %h expected %h", product, expected);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        fall_wait = 0;
        @(negedge clk);
        while (ack && fall_wait < 4) begin
            @(negedge clk);
            fall_wait++;
        end
        assert (ack === 1'b0) else begin
            protocol_errors++;
            $display("ack stayed high after req was dropped");
        end
    endtask

    task automatic test_reset_state;
        assert (ack === 1'b0) else begin
            value_errors++;
            $display("error: ack got %h expected %h", ack, 1'b0);
        end
        assert (product === '0) else begin
            value_errors++;
            $display("error: product got %h expected %h", product, 32'h0);
        end
    endtask

    task automatic test_small_operands;
        multiply(16'sd3, 16'sd5, 0);
        multiply(-16'sd7, 16'sd6, 0);
        multiply(16'sd123, -16'sd45, 0);
        multiply(16'sd0, -16'sd1, 0);
    endtask

    task automatic test_extreme_operands;
        multiply(16'sh8000, 16'sh8000, 0);   // 2^30
        multiply(16'sh7FFF, 16'sh8000, 0);
        multiply(-16'sd1, -16'sd1, 0);
        multiply(16'sd1, 16'sh8000, 0);
    endtask

    task automatic test_random_operands;
        booth_data_pkg::operand_t a;
        booth_data_pkg::operand_t b;
        for (int i = 0; i < 40; i++) begin
            draw_operand(a);
            draw_operand(b);
            multiply(a, b, 0);
        end
    endtask

    task automatic test_handshake;
        multiply(-16'sd300, 16'sd211, 10);   // req held 10 extra cycles
        // Back to back, no idle gap beyond the handshake
        multiply(16'sd1000, 16'sd1000, 0);
        multiply(-16'sd2, 16'sh7FFF, 0);
        multiply(16'sd255, -16'sd256, 0);
    endtask

    initial begin
        rst_n           = 1'b0;
        req             = 1'b0;
        multiplicand    = '0;
        multiplier      = '0;
        value_errors    = 0;
        protocol_errors = 0;
        lfsr_state      = 16'd76;   // Seed
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset_state();
        test_small_operands();
        test_extreme_operands();
        test_random_operands();
        test_handshake();
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not complete", cycles);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== verilog/booth_multiplier.sv ====
`timescale 1ns/1ps
`include "booth_params.svh"

module booth_multiplier (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  booth_data_pkg::operand_t multiplicand,
    input  booth_data_pkg::operand_t multiplier,
    output logic                     ack,
    output booth_data_pkg::product_t product
);

    // Controller to datapath
    logic                    load;
    logic                    step;
    logic                    capture;
    booth_ctrl_pkg::alu_op_t alu_op;

    // Datapath status back to the controller
    logic q0;
    logic q_1;
    logic last_step;

    // Handshake and sequencing
    booth_controller ctrl0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .q0        (q0),
        .q_1       (q_1),
        .last_step (last_step),
        .ack       (ack),
        .load      (load),
        .step      (step),
        .capture   (capture),
        .alu_op    (alu_op)
    );

    // Registers, add/subtract and shift
    booth_datapath #(
        .WIDTH (`BOOTH_WIDTH)
    ) dp0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .step         (step),
        .capture      (capture),
        .alu_op       (alu_op),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .q0           (q0),
        .q_1          (q_1),
        .last_step    (last_step),
        .product      (product)
    );

endmodule

// ==== verilog/booth_controller.sv ====
`timescale 1ns/1ps

module booth_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,         // Four-phase request
    input  logic                    q0,          // Multiplier LSB
    input  logic                    q_1,         // Previous LSB
    input  logic                    last_step,   // Counter at final step
    output logic                    ack,
    output logic                    load,
    output logic                    step,
    output logic                    capture,
    output booth_ctrl_pkg::alu_op_t alu_op
);

    booth_ctrl_pkg::state_t state;
    booth_ctrl_pkg::state_t next_state;
    booth_ctrl_pkg::alu_op_t booth_op;   // Decode of the bit pair

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= booth_ctrl_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            booth_ctrl_pkg::IDLE: begin
                if (req) begin
                    next_state = booth_ctrl_pkg::LOAD;
                end
            end
            booth_ctrl_pkg::LOAD: begin
                next_state = booth_ctrl_pkg::STEP;   // Always a single cycle
            end
            booth_ctrl_pkg::STEP: begin
                if (last_step) begin
                    next_state = booth_ctrl_pkg::DONE;
                end
            end
            booth_ctrl_pkg::DONE: begin
                if (!req) begin   // Requester has seen ack
                    next_state = booth_ctrl_pkg::IDLE;
                end
            end
            default: begin
                next_state = booth_ctrl_pkg::IDLE;
            end
        endcase
    end

    // Radix-2 Booth recoding of {Q0, Q_1}
    always_comb begin
        case ({q0, q_1})
            2'b10:   booth_op = booth_ctrl_pkg::SUB;
            2'b01:   booth_op = booth_ctrl_pkg::ADD;
            default: booth_op = booth_ctrl_pkg::PASS;   // 00 and 11
        endcase
    end

    assign load    = (state == booth_ctrl_pkg::LOAD);
    assign step    = (state == booth_ctrl_pkg::STEP);
    assign capture = step && last_step;   // Product taken with the final shift
    assign ack     = (state == booth_ctrl_pkg::DONE);
    // Only meaningful while stepping
    assign alu_op  = step ? booth_op : booth_ctrl_pkg::PASS;

    // ack only ever reached through the step sequence
    a_ack_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(state == booth_ctrl_pkg::STEP && last_step)
    );

    // Four-phase rule, ack falls only once req is low
    a_ack_fall: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> $past(!req)
    );

endmodule

// ==== verilog/booth_datapath.sv ====
`timescale 1ns/1ps
`include "booth_params.svh"

module booth_datapath #(
    parameter int WIDTH = `BOOTH_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,          // Operands in, accumulator cleared
    input  logic                      step,          // One Booth step
    input  logic                      capture,       // Latch product on last step
    input  booth_ctrl_pkg::alu_op_t   alu_op,
    input  booth_data_pkg::operand_t  multiplicand,
    input  booth_data_pkg::operand_t  multiplier,
    output logic                      q0,
    output logic                      q_1,
    output logic                      last_step,
    output booth_data_pkg::product_t  product
);

    localparam int PWIDTH = 2 * WIDTH;
    // One guard bit so that subtracting -2^(WIDTH-1) cannot overflow
    localparam int AWIDTH = WIDTH + 1;
    localparam int CWIDTH = AWIDTH + WIDTH;   // Accumulator and multiplier together
    localparam booth_data_pkg::count_t LAST = booth_data_pkg::count_t'(`BOOTH_STEPS - 1);

    logic signed [WIDTH-1:0]  mcand_r;        // Multiplicand
    logic signed [AWIDTH-1:0] acc_r;          // Accumulator, upper half of the pair
    logic [WIDTH-1:0]         mq_r;           // Multiplier, lower half of the pair
    logic                     q_1_r;          // Bit shifted out last step
    booth_data_pkg::count_t   count_r;

    logic signed [AWIDTH-1:0] mcand_ext;
    logic signed [AWIDTH-1:0] alu_res;
    logic [CWIDTH-1:0]        combined;
    logic [CWIDTH-1:0]        shifted;

    assign mcand_ext = {mcand_r[WIDTH-1], mcand_r};   // Sign extend to accumulator width

    // Add, subtract or pass
    always_comb begin
        case (alu_op)
            booth_ctrl_pkg::ADD: alu_res = acc_r + mcand_ext;
            booth_ctrl_pkg::SUB: alu_res = acc_r - mcand_ext;
            default:             alu_res = acc_r;
        endcase
    end

    assign combined = {alu_res, mq_r};
    // Arithmetic shift right, sign bit duplicated
    assign shifted  = {combined[CWIDTH-1], combined[CWIDTH-1:1]};

    // Payload registers, no reset
    always_ff @(posedge clk) begin
        if (load) begin
            mcand_r <= multiplicand;
            acc_r   <= '0;
            mq_r    <= multiplier;
        end else if (step) begin
            acc_r <= shifted[CWIDTH-1:WIDTH];
            mq_r  <= shifted[WIDTH-1:0];
        end
    end

    // Q_1 flop and step counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_1_r   <= 1'b0;
            count_r <= '0;
        end else if (load) begin
            q_1_r   <= 1'b0;
            count_r <= '0;
        end else if (step) begin
            q_1_r   <= combined[0];   // LSB shifted out
            count_r <= count_r + 1'b1;
        end
    end

    // Product stays put until the next capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
        end else if (capture) begin
            product <= shifted[PWIDTH-1:0];   // Guard bit dropped, result fits
        end
    end

    assign q0        = mq_r[0];
    assign q_1       = q_1_r;
    assign last_step = (count_r == LAST);

    // Controller never loads mid-product
    a_load_step_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && step)
    );

    // Capture belongs to the final step only
    a_capture_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        capture |-> step && last_step
    );

    // No step beyond the programmed count
    a_step_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        step |-> count_r <= LAST
    );

endmodule

// ==== verilog/booth_data_pkg.sv ====
`include "booth_params.svh"

package booth_data_pkg;

    // Two's-complement operand
    typedef logic signed [`BOOTH_WIDTH-1:0] operand_t;

    // Signed product, wide enough for -2^(n-1) squared
    typedef logic signed [`BOOTH_PWIDTH-1:0] product_t;

    // Step counter
    typedef logic [`BOOTH_CWIDTH-1:0] count_t;

endpackage

// ==== verilog/booth_ctrl_pkg.sv ====
package booth_ctrl_pkg;

    // Controller sequence
    typedef enum logic [1:0] {
        IDLE = 2'd0,   // Waiting for req
        LOAD = 2'd1,   // Operands into registers
        STEP = 2'd2,   // One Booth step per clock
        DONE = 2'd3    // ack high until req drops
    } state_t;

    // Accumulator operation for one step
    typedef enum logic [1:0] {
        PASS = 2'd0,   // Q0 Q_1 = 00 or 11
        ADD  = 2'd1,   // 01, end of a run of ones
        SUB  = 2'd2    // 10, start of a run of ones
    } alu_op_t;

endpackage

// ==== include/booth_params.svh ====
`ifndef BOOTH_PARAMS_SVH
`define BOOTH_PARAMS_SVH

// Operand width of both inputs
`define BOOTH_WIDTH 16

`define BOOTH_PWIDTH (2 * `BOOTH_WIDTH)   // Full signed product

// Counter must reach BOOTH_STEPS after the final increment
`define BOOTH_CWIDTH 5

`define BOOTH_STEPS `BOOTH_WIDTH          // Radix-2, one step per multiplier bit

`endif
